//--- design/core_pkg.sv
// Shared definitions for the bridge-facing console shell.
// Region codes, buffer sizes, sync delay, command opcodes and the
// structs that carry the bridge, loader stream and video signals.

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address map and sizes

  // upper nibble of the rom download window
  localparam logic [3:0] ROM_REGION = 4'h1;
  // upper nibble of the save window
  localparam logic [3:0] SAVE_REGION = 4'h2;
  // upper byte of the host command window
  localparam logic [7:0] CMD_REGION = 8'hF8;

  localparam int SAVE_WORDS = 256;
  // word index comes from address bits 9:2
  localparam int SAVE_AW = 8;

  // clocks from a sampled hsync edge to the output pulse
  localparam int HS_DELAY = 7;

  // host command opcodes
  localparam logic [15:0] CMD_REQUEST_WRITE = 16'h0082;
  localparam logic [15:0] CMD_ALL_COMPLETE = 16'h0080;

  ////////////////////////////////////////////////////////////////////////////
  // bus and stream types

  // one bridge write word, seen as big-endian bytes or as a command
  typedef union packed {
    logic [3:0][7:0] bytes;
    struct packed {
      logic [15:0] opcode;
      logic [15:0] slot_id;
    } cmd;
  } bridge_word_u;

  typedef struct packed {
    logic [31:0]  addr;
    logic         rd;
    logic         wr;
    bridge_word_u wr_data;
  } bridge_req_t;

  typedef struct packed {
    logic       wr;
    logic [7:0] dout;
  } rom_stream_t;

  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } game_video_t;

  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } shell_video_t;

endpackage

//--- design/rom_byte_streamer.sv
// Turns 32-bit bridge writes into the rom region into a byte stream.
// Bytes leave most significant first, one per clock, four clocks per word.
`timescale 1ns/1ps

module rom_byte_streamer (
  input  logic                   clk_74a,
  input  logic                   rst_n,
  input  core_pkg::bridge_req_t  req,
  output core_pkg::rom_stream_t  rom
);

  logic                   rom_hit;
  logic                   busy;
  logic [1:0]             byte_cnt;
  core_pkg::bridge_word_u word_q;
  logic                   wr_q;
  logic [7:0]             dout_q;

  assign rom_hit = req.wr && (req.addr[31:28] == core_pkg::ROM_REGION);

  // control state
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      byte_cnt <= 2'd0;
      wr_q     <= 1'b0;
    end else begin
      wr_q <= busy;
      if (busy) begin
        byte_cnt <= byte_cnt - 2'd1;
        // last byte goes out on this edge
        if (byte_cnt == 2'd0)
          busy <= 1'b0;
      end else if (rom_hit) begin
        busy     <= 1'b1;
        byte_cnt <= 2'd3;
      end
    end
  end

  // word holding and byte select
  always_ff @(posedge clk_74a) begin
    if (!busy && rom_hit)
      word_q <= req.wr_data;
    if (busy)
      dout_q <= word_q.bytes[byte_cnt];
  end

  assign rom = '{wr: wr_q, dout: dout_q};

  // host keeps rom writes far enough apart
  a_no_write_while_busy: assert property (
    @(posedge clk_74a) disable iff (!rst_n) rom_hit |-> !busy
  );

endmodule

//--- design/save_ram_window.sv
// Save buffer reached through the bridge save window.
// Writes land on the sampling edge, every read strobe registers the
// addressed word for the read multiplexer.
`timescale 1ns/1ps

module save_ram_window (
  input  logic                  clk_74a,
  input  logic                  rst_n,
  input  core_pkg::bridge_req_t req,
  output logic [31:0]           rd_word
);

  logic [31:0]                  mem [core_pkg::SAVE_WORDS];
  logic [core_pkg::SAVE_AW-1:0] idx;
  logic                         save_wr;

  // word index from the byte address
  assign idx     = req.addr[core_pkg::SAVE_AW+1:2];
  assign save_wr = req.wr && (req.addr[31:28] == core_pkg::SAVE_REGION);

  always_ff @(posedge clk_74a) begin
    if (save_wr)
      mem[idx] <= req.wr_data;
  end

  // region check is left to the read mux
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n)
      rd_word <= 32'd0;
    else if (req.rd)
      rd_word <= mem[idx];
  end

endmodule

//--- design/host_cmd_status.sv
// Host command decoder for the command window.
// Request-write starts a download and all-complete ends it. The status
// word reports the download flag and the last slot id.
`timescale 1ns/1ps

module host_cmd_status (
  input  logic                  clk_74a,
  input  logic                  rst_n,
  input  core_pkg::bridge_req_t req,
  output logic                  download,
  output logic [31:0]           status_word
);

  logic        cmd_wr;
  logic        req_write_seen;
  logic [15:0] slot_id;

  assign cmd_wr = req.wr && (req.addr[31:24] == core_pkg::CMD_REGION);
  assign req_write_seen = cmd_wr &&
                          (req.wr_data.cmd.opcode == core_pkg::CMD_REQUEST_WRITE);

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      download <= 1'b0;
      slot_id  <= 16'd0;
    end else if (cmd_wr) begin
      case (req.wr_data.cmd.opcode)
        core_pkg::CMD_REQUEST_WRITE: begin
          download <= 1'b1;
          slot_id  <= req.wr_data.cmd.slot_id;
        end
        core_pkg::CMD_ALL_COMPLETE: begin
          download <= 1'b0;
        end
        // unknown opcodes leave state alone
        default: ;
      endcase
    end
  end

  assign status_word = {download, 15'd0, slot_id};

  a_download_needs_request: assert property (
    @(posedge clk_74a) disable iff (!rst_n) $rose(download) |-> $past(req_write_seen)
  );

endmodule

//--- design/bridge_read_mux.sv
// Bridge read data path.
// Latches the region of a read strobe, then registers the matching
// source one clock later. Unmapped regions read as zero.
`timescale 1ns/1ps

module bridge_read_mux (
  input  logic                  clk_74a,
  input  logic                  rst_n,
  input  core_pkg::bridge_req_t req,
  input  logic [31:0]           save_word,
  input  logic [31:0]           status_word,
  output logic [31:0]           rd_data
);

  logic rd_pend;
  logic hit_save;
  logic hit_cmd;

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend  <= 1'b0;
      hit_save <= 1'b0;
      hit_cmd  <= 1'b0;
      rd_data  <= 32'd0;
    end else begin
      rd_pend  <= req.rd;
      hit_save <= req.addr[31:28] == core_pkg::SAVE_REGION;
      hit_cmd  <= req.addr[31:24] == core_pkg::CMD_REGION;
      // save word was registered on the strobe edge
      if (rd_pend)
        rd_data <= hit_save ? save_word : (hit_cmd ? status_word : 32'd0);
    end
  end

  a_rd_wr_exclusive: assert property (
    @(posedge clk_74a) disable iff (!rst_n) !(req.rd && req.wr)
  );

endmodule

//--- design/video_sync_shaper.sv
// Video output shaping for the scaler.
// Data enable follows the blanking inputs, pixels are zeroed outside
// the active area, vsync becomes a one clock pulse and hsync a one
// clock pulse delayed by a fixed count.
`timescale 1ns/1ps

module video_sync_shaper (
  input  logic                   clk_74a,
  input  logic                   rst_n,
  input  core_pkg::game_video_t  game,
  output core_pkg::shell_video_t shell
);

  localparam int CNT_W = $clog2(core_pkg::HS_DELAY + 1);

  logic             hs_prev;
  logic             vs_prev;
  logic [CNT_W-1:0] hs_cnt;
  logic             active;

  assign active = !(game.hblank || game.vblank);

  ////////////////////////////////////////////////////////////////////////////
  // sync edges and output registers

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
      hs_cnt  <= '0;
      shell   <= '0;
    end else begin
      hs_prev   <= game.hs;
      vs_prev   <= game.vs;
      shell.de  <= active;
      shell.rgb <= active ? game.rgb : 24'd0;
      shell.vs  <= game.vs && !vs_prev;
      shell.hs  <= hs_cnt == CNT_W'(1);

      // a new hsync edge restarts the delay
      if (game.hs && !hs_prev)
        hs_cnt <= CNT_W'(core_pkg::HS_DELAY);
      else if (hs_cnt != '0)
        hs_cnt <= hs_cnt - CNT_W'(1);
    end
  end

endmodule

//--- design/pocket_core_shell.sv
// Top level of the console shell on clk_74a.
// Packs the bridge signals into one request and hands it to the rom
// streamer, save window, command block and read mux. The video shaper
// sits beside them.
`timescale 1ns/1ps

module pocket_core_shell (
  input  logic                   clk_74a,
  input  logic                   rst_n,

  // bridge bus, big-endian
  input  logic [31:0]            bridge_addr,
  input  logic                   bridge_rd,
  input  logic                   bridge_wr,
  input  logic [31:0]            bridge_wr_data,
  output logic [31:0]            bridge_rd_data,

  // loader stream toward the core
  output logic                   ioctl_wr,
  output logic [7:0]             ioctl_dout,
  output logic                   ioctl_download,

  // video
  input  core_pkg::game_video_t  game_video,
  output logic [23:0]            video_rgb,
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs
);

  core_pkg::bridge_req_t  req;
  core_pkg::rom_stream_t  rom;
  core_pkg::shell_video_t shell;
  logic [31:0]            save_word;
  logic [31:0]            status_word;

  assign req = {bridge_addr, bridge_rd, bridge_wr, bridge_wr_data};

  ////////////////////////////////////////////////////////////////////////////
  // bridge blocks

  rom_byte_streamer u_rom_stream (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .req     (req),
    .rom     (rom)
  );

  save_ram_window u_save (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .req     (req),
    .rd_word (save_word)
  );

  host_cmd_status u_cmd (
    .clk_74a     (clk_74a),
    .rst_n       (rst_n),
    .req         (req),
    .download    (ioctl_download),
    .status_word (status_word)
  );

  bridge_read_mux u_rd_mux (
    .clk_74a     (clk_74a),
    .rst_n       (rst_n),
    .req         (req),
    .save_word   (save_word),
    .status_word (status_word),
    .rd_data     (bridge_rd_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // video

  video_sync_shaper u_video (
    .clk_74a (clk_74a),
    .rst_n   (rst_n),
    .game    (game_video),
    .shell   (shell)
  );

  assign ioctl_wr   = rom.wr;
  assign ioctl_dout = rom.dout;
  assign video_rgb  = shell.rgb;
  assign video_de   = shell.de;
  assign video_hs   = shell.hs;
  assign video_vs   = shell.vs;

endmodule

//--- testbench/tb_clock_gen.sv
// Clock and reset source for the shell testbench.
// 100 ns clock on clk_74a, rst_n held low for the first four cycles.
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_74a,
  output logic rst_n
);

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_74a = 1'b0;
    forever #(PERIOD_NS / 2) clk_74a = ~clk_74a;
  end

  // release on a rising edge, same as any other driven input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_74a);
    rst_n <= 1'b1;
  end

endmodule

//--- testbench/tb_core_shell.sv
// Testbench for the console shell top level.
// Reads bridge and video operations from the stimulus file, drives them on
// the rising edge and checks responses at the falling edge.
`timescale 1ns/1ps

module tb_core_shell;

  localparam string STIM_FILE = "testbench/core_stimulus.txt";
  localparam int    MAX_OPS   = 128;
  localparam int    MAX_RUN   = 1024;
  // idle clocks after a video run so a pending hsync pulse drains
  localparam int    TAIL      = core_pkg::HS_DELAY + 2;

  logic                  clk_74a;
  logic                  rst_n;
  logic [31:0]           bridge_addr;
  logic                  bridge_rd;
  logic                  bridge_wr;
  logic [31:0]           bridge_wr_data;
  logic [31:0]           bridge_rd_data;
  logic                  ioctl_wr;
  logic [7:0]            ioctl_dout;
  logic                  ioctl_download;
  core_pkg::game_video_t game_video;
  logic [23:0]           video_rgb;
  logic                  video_de;
  logic                  video_hs;
  logic                  video_vs;

  byte                   op_kind [MAX_OPS];
  logic [31:0]           op_addr [MAX_OPS];
  logic [31:0]           op_data [MAX_OPS];
  logic [31:0]           op_exp [MAX_OPS];
  int                    n_ops;
  int                    video_cycles;
  int                    watchdog_cycles;
  logic                  watchdog_armed;
  int                    errors;
  int                    checks;
  logic [31:0]           lfsr;
  core_pkg::game_video_t vid [MAX_RUN];
  logic                  rise [MAX_RUN];

  tb_clock_gen u_clk (
    .clk_74a (clk_74a),
    .rst_n   (rst_n)
  );

  pocket_core_shell u_dut (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .ioctl_wr       (ioctl_wr),
    .ioctl_dout     (ioctl_dout),
    .ioctl_download (ioctl_download),
    .game_video     (game_video),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, expected, $time);
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic random_bits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd) && n_ops < MAX_OPS) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%c %h %h %h", kind, a, d, e);
      // comment and blank lines do not parse to four fields
      if (n == 4 && (kind == "W" || kind == "R" || kind == "V")) begin
        if (kind == "V" && int'(a) + TAIL >= MAX_RUN) begin
          errors++;
          $display("video run of %0d clocks is too long, skipped", a);
        end else begin
          op_kind[n_ops] = kind;
          op_addr[n_ops] = a;
          op_data[n_ops] = d;
          op_exp[n_ops]  = e;
          n_ops++;
          if (kind == "V")
            video_cycles += int'(a) + TAIL;
        end
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      errors++;
      $display("the stimulus file holds no operations");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bridge operations

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] exp_download);
    logic rom_hit;
    logic exp_wr;
    rom_hit = addr[31:28] == core_pkg::ROM_REGION;
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    // sampling edge, four byte clocks, one idle clock
    for (int i = 0; i < 6; i++) begin
      if (i > 0)
        @(posedge clk_74a);
      @(negedge clk_74a);
      if (i == 0)
        check_value("ioctl_download", 32'(ioctl_download), exp_download);
      exp_wr = rom_hit && i >= 1 && i <= 4;
      check_value("ioctl_wr", 32'(ioctl_wr), 32'(exp_wr));
      // big-endian, byte 3 first
      if (exp_wr)
        check_value("ioctl_dout", 32'(ioctl_dout), 32'(data[8 * (4 - i) +: 8]));
    end
  endtask

  task automatic bridge_read(input logic [31:0] addr, input logic [31:0] expected);
    @(posedge clk_74a);
    bridge_addr <= addr;
    bridge_rd   <= 1'b1;
    @(posedge clk_74a);
    bridge_rd <= 1'b0;
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_value("bridge_rd_data", bridge_rd_data, expected);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // video runs, gap 0 is random, otherwise two hsync edges gap clocks apart

  task automatic video_run(input int length, input int gap, input int exp_pulses);
    logic [31:0] bits;
    int          total;
    int          pulses;
    int          j;
    logic        exp_de;
    logic        exp_hs;
    total   = length + TAIL;
    vid[0]  = '0;
    rise[0] = 1'b0;
    for (int k = 1; k <= total; k++) begin
      vid[k] = '0;
      if (k <= length && gap == 0) begin
        random_bits(4, bits);
        vid[k].hblank = bits[3];
        vid[k].vblank = bits[2];
        vid[k].hs     = bits[1];
        vid[k].vs     = bits[0];
        random_bits(24, bits);
        vid[k].rgb = bits[23:0];
      end else if (k <= length) begin
        vid[k].hs = (k == 2) || (k == 2 + gap);
      end
      rise[k] = vid[k].hs && !vid[k - 1].hs;
    end
    pulses = 0;
    for (int k = 1; k <= total; k++) begin
      @(posedge clk_74a);
      game_video <= vid[k];
      @(negedge clk_74a);
      // outputs now reflect the sample taken on this edge
      j = k - 1;
      if (j >= 1) begin
        exp_de = !(vid[j].hblank || vid[j].vblank);
        check_value("video_de", 32'(video_de), 32'(exp_de));
        check_value("video_rgb", 32'(video_rgb), exp_de ? 32'(vid[j].rgb) : 32'd0);
        check_value("video_vs", 32'(video_vs), 32'(vid[j].vs && !vid[j - 1].vs));
        // pulse needs an edge HS_DELAY back and no newer edge since
        exp_hs = (j - core_pkg::HS_DELAY >= 1) && rise[j - core_pkg::HS_DELAY];
        for (int m = j - core_pkg::HS_DELAY + 1; m < j; m++) begin
          if (m >= 1 && rise[m])
            exp_hs = 1'b0;
        end
        check_value("video_hs", 32'(video_hs), 32'(exp_hs));
        if (video_hs)
          pulses++;
      end
    end
    if (gap != 0)
      check_value("video_hs pulses", pulses, exp_pulses);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin : watchdog
    wait (watchdog_armed === 1'b1);
    repeat (watchdog_cycles) @(posedge clk_74a);
    $display("timeout: the tests did not finish within %0d clocks", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus_driver
    bridge_addr    = '0;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    game_video     = '0;
    errors         = 0;
    checks         = 0;
    n_ops          = 0;
    video_cycles   = 0;
    lfsr           = 32'd82526;
    watchdog_armed = 1'b0;

    load_stimulus();
    watchdog_cycles = n_ops * 20 + video_cycles + 100;
    watchdog_armed  = 1'b1;

    wait (rst_n === 1'b1);
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_value("bridge_rd_data", bridge_rd_data, 32'd0);
    check_value("ioctl_wr", 32'(ioctl_wr), 32'd0);
    check_value("ioctl_download", 32'(ioctl_download), 32'd0);

    for (int i = 0; i < n_ops; i++) begin
      case (op_kind[i])
        "W": bridge_write(op_addr[i], op_data[i], op_exp[i]);
        "R": bridge_read(op_addr[i], op_exp[i]);
        "V": video_run(int'(op_addr[i]), int'(op_data[i]), int'(op_exp[i]));
        default: ;
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/core_stimulus.txt
# kind addr data expected, all hex
# W: expected is ioctl_download after the write. R: expected is the read data.
# V: addr is the run length, data is 0 for a random run or the gap between two
#    hsync edges, expected is the hsync pulse count of a gap run
R 00000000 00000000 00000000
W 10000000 A1B2C3D4 00000000
W 10000004 00FF7E81 00000000
W 20000000 11111111 00000000
W 20000004 22222222 00000000
W 200003FC CAFEF00D 00000000
W 20000100 0BADC0DE 00000000
R 20000004 00000000 22222222
R 200003FC 00000000 CAFEF00D
R 20000000 00000000 11111111
R 20000100 00000000 0BADC0DE
W 20000000 12345678 00000000
R 20000000 00000000 12345678
R 20000004 00000000 22222222
R F8000000 00000000 00000000
W F8000000 00820005 00000001
R F8000000 00000000 80000005
W F8000000 12340009 00000001
R F8000000 00000000 80000005
W 1FFFFFFC DEADBEEF 00000001
W F8000004 00800000 00000000
R F8000000 00000000 00000005
R 30000000 00000000 00000000
R 10000000 00000000 00000000
R F7000000 00000000 00000000
V 00000100 00000000 00000000
V 00000028 00000014 00000002
V 00000020 00000006 00000001
V 00000020 00000007 00000002
V 00000020 00000003 00000001
V 00000040 00000000 00000000

//--- sources.f
design/core_pkg.sv
design/rom_byte_streamer.sv
design/save_ram_window.sv
design/host_cmd_status.sv
design/bridge_read_mux.sv
design/video_sync_shaper.sv
design/pocket_core_shell.sv
testbench/tb_clock_gen.sv
testbench/tb_core_shell.sv

//--- Makefile
# Verilator build and run for the console shell testbench

VERILATOR ?= verilator
TOP       ?= tb_core_shell
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
